//--- logic/div_pkg.sv
// Shared sizes and op codes for the divide cluster, referenced by scoped name from RTL and bench
package div_pkg;

  // Operand and result width
  localparam int XLEN = 32;

  // Request tag carried through a lane
  localparam int TAG_W = 4;

  // Lane count and lane index width
  localparam int NUM_LANES = 4;
  localparam int LANE_W = $clog2(NUM_LANES);

  // One quotient bit per iteration
  localparam int ITERS = XLEN;
  localparam int ITER_W = $clog2(ITERS);

  // Op bit 0 selects unsigned, op bit 1 selects remainder
  localparam logic [1:0] OP_DIV = 2'b00;
  localparam logic [1:0] OP_DIVU = 2'b01;
  localparam logic [1:0] OP_REM = 2'b10;
  localparam logic [1:0] OP_REMU = 2'b11;

endpackage

//--- logic/div_dispatch.sv
// Request steering for the divide cluster: picks an idle lane round-robin and reports busy
module div_dispatch (
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic                           req,
  input  logic [div_pkg::NUM_LANES-1:0]  lane_idle,
  output logic [div_pkg::NUM_LANES-1:0]  lane_req,
  output logic                           busy
);

  // Lane to start the next search from
  logic [div_pkg::LANE_W-1:0] ptr;

  logic                       found;
  logic [div_pkg::LANE_W-1:0] sel;
  logic                       accept;

  // First idle lane at or after the pointer
  always_comb begin
    logic [div_pkg::LANE_W-1:0] idx;
    found = 1'b0;
    sel = '0;
    idx = '0;
    for (int i = 0; i < div_pkg::NUM_LANES; i++) begin
      idx = ptr + div_pkg::LANE_W'(i);
      if (!found && lane_idle[idx]) begin
        found = 1'b1;
        sel = idx;
      end
    end
  end

  assign accept = req && found;

  always_comb begin
    lane_req = '0;
    if (accept) begin
      lane_req[sel] = 1'b1;
    end
  end

  assign busy = ~|lane_idle;

  // Move past the lane just used
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      ptr <= '0;
    end else if (accept) begin
      ptr <= sel + 1'b1;
    end
  end

endmodule

//--- logic/div_lane.sv
// One iterative restoring divider lane; the cluster builds several and hands each one request
module div_lane (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        req,
  input  logic [1:0]                  op,
  input  logic [div_pkg::XLEN-1:0]    op1,
  input  logic [div_pkg::XLEN-1:0]    op2,
  input  logic [div_pkg::TAG_W-1:0]   tag_in,
  input  logic                        stall,
  output logic                        idle,
  output logic                        done,
  output logic [div_pkg::XLEN-1:0]    result,
  output logic [div_pkg::TAG_W-1:0]   tag_out
);

  typedef enum logic [1:0] {
    S_IDLE  = 2'b00,
    S_ITER  = 2'b01,
    S_FINAL = 2'b10
  } state_t;

  state_t state;
  logic   done_q;

  // Operation context latched at accept
  logic [1:0]                 op_q;
  logic [div_pkg::TAG_W-1:0]  tag_q;
  logic                       dvd_sgn_q;
  logic                       dsor_sgn_q;
  logic                       dsor_zero_q;
  logic [div_pkg::XLEN+1:0]   dsor_neg;

  // Remainder in the upper half, quotient bits shift into the lower half
  logic [2*div_pkg::XLEN-1:0] acc;
  logic [div_pkg::ITER_W-1:0] iter;
  logic [div_pkg::XLEN-1:0]   result_q;

  logic                       is_unsigned;
  logic                       dvd_sgn;
  logic                       dsor_sgn;
  logic [div_pkg::XLEN-1:0]   dvd_mag;
  logic [div_pkg::XLEN+1:0]   dsor_in;

  assign is_unsigned = (op == div_pkg::OP_DIVU) || (op == div_pkg::OP_REMU);
  assign dvd_sgn = op1[div_pkg::XLEN-1] & ~is_unsigned;
  assign dsor_sgn = op2[div_pkg::XLEN-1] & ~is_unsigned;
  assign dvd_mag = dvd_sgn ? (~op1 + 1'b1) : op1;
  // Minus the divisor magnitude, so the trial subtract is an add
  assign dsor_in = dsor_sgn ? {2'b11, op2} : ({2'b11, ~op2} + 1'b1);

  logic [div_pkg::XLEN+1:0]   ptl_rem;
  logic [div_pkg::XLEN+1:0]   cmp_res;
  logic [div_pkg::XLEN-1:0]   rem_next;
  logic [div_pkg::XLEN-1:0]   quo_shf;

  assign ptl_rem = {1'b0, acc[2*div_pkg::XLEN-1:div_pkg::XLEN-1]};
  assign cmp_res = ptl_rem + dsor_neg;
  // Negative trial result means restore
  assign rem_next = cmp_res[div_pkg::XLEN+1] ? ptl_rem[div_pkg::XLEN-1:0]
                                             : cmp_res[div_pkg::XLEN-1:0];
  assign quo_shf = {acc[div_pkg::XLEN-2:0], ~cmp_res[div_pkg::XLEN+1]};

  logic                       rem_sel;
  logic                       neg_res;
  logic [div_pkg::XLEN-1:0]   raw_res;
  logic [div_pkg::XLEN-1:0]   fin_res;

  assign rem_sel = (op_q == div_pkg::OP_REM) || (op_q == div_pkg::OP_REMU);
  assign raw_res = rem_sel ? acc[2*div_pkg::XLEN-1:div_pkg::XLEN] : acc[div_pkg::XLEN-1:0];
  // Zero divisor keeps the all-ones quotient unsigned
  assign neg_res = rem_sel ? dvd_sgn_q : ((dvd_sgn_q ^ dsor_sgn_q) & ~dsor_zero_q);
  assign fin_res = neg_res ? (~raw_res + 1'b1) : raw_res;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= S_IDLE;
      done_q <= 1'b0;
    end else begin
      case (state)
        S_IDLE: begin
          if (req) begin
            state <= S_ITER;
          end
        end
        S_ITER: begin
          if (iter == '0) begin
            state <= S_FINAL;
          end
        end
        S_FINAL: begin
          if (!done_q) begin
            done_q <= 1'b1;
          end else if (!stall) begin
            // Collector took the result
            done_q <= 1'b0;
            state <= S_IDLE;
          end
        end
        default: begin
          state <= S_IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    case (state)
      S_IDLE: begin
        if (req) begin
          op_q <= op;
          tag_q <= tag_in;
          dvd_sgn_q <= dvd_sgn;
          dsor_sgn_q <= dsor_sgn;
          dsor_zero_q <= (op2 == '0);
          dsor_neg <= dsor_in;
          acc <= {{div_pkg::XLEN{1'b0}}, dvd_mag};
          iter <= div_pkg::ITER_W'(div_pkg::ITERS - 1);
        end
      end
      S_ITER: begin
        acc <= {rem_next, quo_shf};
        iter <= iter - 1'b1;
      end
      S_FINAL: begin
        if (!done_q) begin
          result_q <= fin_res;
        end
      end
      default: begin
      end
    endcase
  end

  assign idle = (state == S_IDLE);
  assign done = done_q;
  assign result = result_q;
  assign tag_out = tag_q;

endmodule

//--- logic/div_collect.sv
// Result merge for the divide cluster: drains finished lanes round-robin into a stallable register
module div_collect (
  input  logic                                              clk,
  input  logic                                              rst_n,
  input  logic [div_pkg::NUM_LANES-1:0]                     lane_done,
  input  logic [div_pkg::NUM_LANES-1:0][div_pkg::XLEN-1:0]  lane_result,
  input  logic [div_pkg::NUM_LANES-1:0][div_pkg::TAG_W-1:0] lane_tag,
  input  logic                                              stall,
  output logic [div_pkg::NUM_LANES-1:0]                     lane_stall,
  output logic                                              done,
  output logic [div_pkg::XLEN-1:0]                          result,
  output logic [div_pkg::TAG_W-1:0]                         result_tag
);

  logic [div_pkg::LANE_W-1:0] ptr;
  logic                       done_q;
  logic [div_pkg::XLEN-1:0]   result_q;
  logic [div_pkg::TAG_W-1:0]  tag_q;

  logic                       load_en;
  logic                       found;
  logic [div_pkg::LANE_W-1:0] sel;
  logic                       grant;

  // Output empty, or being consumed this cycle
  assign load_en = !done_q || !stall;

  always_comb begin
    logic [div_pkg::LANE_W-1:0] idx;
    found = 1'b0;
    sel = '0;
    idx = '0;
    for (int i = 0; i < div_pkg::NUM_LANES; i++) begin
      idx = ptr + div_pkg::LANE_W'(i);
      if (!found && lane_done[idx]) begin
        found = 1'b1;
        sel = idx;
      end
    end
  end

  assign grant = load_en && found;

  // Only the granted lane sees its stall drop
  always_comb begin
    lane_stall = '1;
    if (grant) begin
      lane_stall[sel] = 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      done_q <= 1'b0;
      ptr <= '0;
    end else if (load_en) begin
      done_q <= found;
      if (found) begin
        ptr <= sel + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (grant) begin
      result_q <= lane_result[sel];
      tag_q <= lane_tag[sel];
    end
  end

  assign done = done_q;
  assign result = result_q;
  assign result_tag = tag_q;

endmodule

//--- logic/div_cluster.sv
// Top of the multi-lane divide unit: dispatcher, divider lanes and result collector
module div_cluster (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        req,
  input  logic [1:0]                  op,
  input  logic [div_pkg::XLEN-1:0]    op1,
  input  logic [div_pkg::XLEN-1:0]    op2,
  input  logic [div_pkg::TAG_W-1:0]   tag,
  input  logic                        stall,
  output logic                        busy,
  output logic                        done,
  output logic [div_pkg::XLEN-1:0]    result,
  output logic [div_pkg::TAG_W-1:0]   result_tag
);

  logic [div_pkg::NUM_LANES-1:0]                     lane_req;
  logic [div_pkg::NUM_LANES-1:0]                     lane_idle;
  logic [div_pkg::NUM_LANES-1:0]                     lane_done;
  logic [div_pkg::NUM_LANES-1:0]                     lane_stall;
  logic [div_pkg::NUM_LANES-1:0][div_pkg::XLEN-1:0]  lane_result;
  logic [div_pkg::NUM_LANES-1:0][div_pkg::TAG_W-1:0] lane_tag;

  div_dispatch u_dispatch (
    .clk       (clk),
    .rst_n     (rst_n),
    .req       (req),
    .lane_idle (lane_idle),
    .lane_req  (lane_req),
    .busy      (busy)
  );

  // Operands go to every lane, lane_req picks who latches them
  for (genvar g = 0; g < div_pkg::NUM_LANES; g++) begin : g_lane
    div_lane u_lane (
      .clk     (clk),
      .rst_n   (rst_n),
      .req     (lane_req[g]),
      .op      (op),
      .op1     (op1),
      .op2     (op2),
      .tag_in  (tag),
      .stall   (lane_stall[g]),
      .idle    (lane_idle[g]),
      .done    (lane_done[g]),
      .result  (lane_result[g]),
      .tag_out (lane_tag[g])
    );
  end

  div_collect u_collect (
    .clk         (clk),
    .rst_n       (rst_n),
    .lane_done   (lane_done),
    .lane_result (lane_result),
    .lane_tag    (lane_tag),
    .stall       (stall),
    .lane_stall  (lane_stall),
    .done        (done),
    .result      (result),
    .result_tag  (result_tag)
  );

endmodule

//--- tests/div_tb_props.sv
// Protocol assertions bound into the divide cluster top by the bind at the end of this file
module div_tb_props (
  input logic                          clk,
  input logic                          rst_n,
  input logic                          req,
  input logic                          busy,
  input logic                          done,
  input logic                          stall,
  input logic [div_pkg::XLEN-1:0]      result,
  input logic [div_pkg::TAG_W-1:0]     result_tag,
  input logic [div_pkg::NUM_LANES-1:0] lane_req,
  input logic [div_pkg::NUM_LANES-1:0] lane_idle
);
  timeunit 1ns;
  timeprecision 1ps;

  int fail_count = 0;

  no_req_when_busy: assert property (@(posedge clk) disable iff (!rst_n) req |-> !busy)
    else begin
      fail_count++;
      $error("req asserted while busy");
    end

  // Output register holds while the consumer stalls
  output_held: assert property (@(posedge clk) disable iff (!rst_n)
    done && stall |=> $stable(result) && $stable(result_tag))
    else begin
      fail_count++;
      $error("output changed while done and stall were high");
    end

  // The steered lane is unique and leaves idle on the accept edge
  single_lane_steer: assert property (@(posedge clk) disable iff (!rst_n)
    |lane_req |=> $onehot($past(lane_req)) && (($past(lane_req) & lane_idle) == '0))
    else begin
      fail_count++;
      $error("lane_req was not one-hot or the chosen lane did not start");
    end

  quiet_after_reset: assert property (@(posedge clk) $rose(rst_n) |-> !done)
    else begin
      fail_count++;
      $error("done high in the first cycle after reset");
    end

endmodule

bind div_cluster div_tb_props u_props (
  .clk        (clk),
  .rst_n      (rst_n),
  .req        (req),
  .busy       (busy),
  .done       (done),
  .stall      (stall),
  .result     (result),
  .result_tag (result_tag),
  .lane_req   (lane_req),
  .lane_idle  (lane_idle)
);

//--- tests/div_tb.sv
// Testbench top that drives LFSR requests into the divide cluster and checks a RISC-V model
module div_tb;
  timeunit 1ns;
  timeprecision 1ps;

  logic                       clk;
  logic                       rst_n;
  logic                       req;
  logic [1:0]                 op;
  logic [div_pkg::XLEN-1:0]   op1;
  logic [div_pkg::XLEN-1:0]   op2;
  logic [div_pkg::TAG_W-1:0]  tag;
  logic                       stall;
  logic                       busy;
  logic                       done;
  logic [div_pkg::XLEN-1:0]   result;
  logic [div_pkg::TAG_W-1:0]  result_tag;

  logic [31:0]                lfsr;
  logic [div_pkg::XLEN-1:0]   expected [2**div_pkg::TAG_W];
  logic                       pending [2**div_pkg::TAG_W];
  logic [div_pkg::TAG_W-1:0]  next_tag;
  int                         issued;
  int                         returned;
  int                         errors;
  int                         tests_run;
  int                         cycles;
  bit                         stall_on;
  bit                         timed_out;
  logic                       held;
  logic [div_pkg::XLEN-1:0]   held_result;
  logic [div_pkg::TAG_W-1:0]  held_tag;

  div_cluster DUT (
    .clk        (clk),
    .rst_n      (rst_n),
    .req        (req),
    .op         (op),
    .op1        (op1),
    .op2        (op2),
    .tag        (tag),
    .stall      (stall),
    .busy       (busy),
    .done       (done),
    .result     (result),
    .result_tag (result_tag)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // Galois LFSR with taps x^32 + x^22 + x^2 + x + 1
  function automatic logic next_bit();
    logic lsb;
    lsb = lfsr[0];
    lfsr = lfsr >> 1;
    if (lsb) begin
      lfsr = lfsr ^ 32'h8020_0003;
    end
    return lsb;
  endfunction

  function automatic logic [div_pkg::XLEN-1:0] random_word(int n);
    logic [div_pkg::XLEN-1:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[div_pkg::XLEN-2:0], next_bit()};
    end
    return v;
  endfunction

  function automatic logic [div_pkg::XLEN-1:0] most_negative();
    return {1'b1, {(div_pkg::XLEN-1){1'b0}}};
  endfunction

  function automatic logic [1:0] random_op();
    return 2'(random_word(2));
  endfunction

  // Corner values show up often
  function automatic logic [div_pkg::XLEN-1:0] pick_operand();
    logic [2:0] kind;
    kind = 3'(random_word(3));
    case (kind)
      3'd0: return '0;
      3'd1: return '1;
      3'd2: return most_negative();
      3'd3: return random_word(4);
      default: return random_word(div_pkg::XLEN);
    endcase
  endfunction

  // Expected result under the RISC-V M rules
  function automatic logic [div_pkg::XLEN-1:0] model(logic [1:0] code,
      logic [div_pkg::XLEN-1:0] a, logic [div_pkg::XLEN-1:0] b);
    logic signed [div_pkg::XLEN-1:0] sa;
    logic signed [div_pkg::XLEN-1:0] sb;
    sa = a;
    sb = b;
    if (b == '0) begin
      return code[1] ? a : '1;
    end
    if (code[0]) begin
      return code[1] ? a % b : a / b;
    end
    if (a == most_negative() && b == '1) begin
      return code[1] ? '0 : a;
    end
    return code[1] ? sa % sb : sa / sb;
  endfunction

  task automatic check_result(logic [div_pkg::XLEN-1:0] got, logic [div_pkg::XLEN-1:0] exp,
      string what);
    if (got !== exp) begin
      errors++;
      $display("MISMATCH at %0t: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_tag(logic [div_pkg::TAG_W-1:0] got, logic [div_pkg::TAG_W-1:0] exp,
      string what);
    if (got !== exp) begin
      errors++;
      $display("MISMATCH at %0t: %s is %0d, expected %0d", $time, what, got, exp);
    end
  endtask

  task automatic check_bit(logic got, logic exp, string what);
    if (got !== exp) begin
      errors++;
      $display("MISMATCH at %0t: %s is %b, expected %b", $time, what, got, exp);
    end
  endtask

  task automatic check_cycles(int got, int exp, string what);
    if (got != exp) begin
      errors++;
      $display("MISMATCH at %0t: %s took %0d cycles, expected %0d", $time, what, got, exp);
    end
  endtask

  task automatic note_timeout(string what);
    errors++;
    timed_out = 1'b1;
    $display("Gave up at %0t after waiting too long for %s", $time, what);
  endtask

  task automatic report(string name);
    tests_run++;
    $display("Test %0d (%s) finished with %0d errors so far", tests_run, name, errors);
  endtask

  task automatic advance();
    @(posedge clk);
    req <= 1'b0;
    stall <= stall_on ? next_bit() : 1'b0;
  endtask

  task automatic send(logic [1:0] code, logic [div_pkg::XLEN-1:0] a,
      logic [div_pkg::XLEN-1:0] b);
    if (pending[next_tag]) begin
      errors++;
      $display("Tag %0d was issued again while still outstanding", next_tag);
    end
    req <= 1'b1;
    op <= code;
    op1 <= a;
    op2 <= b;
    tag <= next_tag;
    stall <= stall_on ? next_bit() : 1'b0;
    expected[next_tag] = model(code, a, b);
    pending[next_tag] = 1'b1;
    next_tag = next_tag + div_pkg::TAG_W'(1);
    issued++;
  endtask

  // Waits at falling edges until some lane is idle
  task automatic wait_free();
    int waited;
    waited = 0;
    @(negedge clk);
    while (busy && !timed_out) begin
      if (waited == 2000) begin
        note_timeout("a free lane");
      end else begin
        advance();
        waited++;
        @(negedge clk);
      end
    end
  endtask

  task automatic issue(logic [1:0] code, logic [div_pkg::XLEN-1:0] a,
      logic [div_pkg::XLEN-1:0] b);
    wait_free();
    if (!timed_out) begin
      @(posedge clk);
      send(code, a, b);
      advance();
    end
  endtask

  task automatic wait_done();
    cycles = 0;
    @(negedge clk);
    while (!done && !timed_out) begin
      if (cycles == 2000) begin
        note_timeout("done");
      end else begin
        advance();
        cycles++;
        @(negedge clk);
      end
    end
  endtask

  task automatic drain();
    int waited;
    waited = 0;
    @(negedge clk);
    while (returned != issued && !timed_out) begin
      if (waited == 2000) begin
        note_timeout("outstanding results");
      end else begin
        advance();
        waited++;
        @(negedge clk);
      end
    end
  endtask

  // Consumer retires a result on each edge with done high and stall low
  always @(posedge clk) begin
    if (!rst_n) begin
      held = 1'b0;
    end else begin
      if (held) begin
        check_result(result, held_result, "result held under stall");
        check_tag(result_tag, held_tag, "tag held under stall");
      end
      if (done && !stall) begin
        if (!pending[result_tag]) begin
          errors++;
          $display("Tag %0d came back without an outstanding request", result_tag);
        end else begin
          check_result(result, expected[result_tag], "result");
          pending[result_tag] = 1'b0;
          returned++;
        end
      end
      held = done && stall;
      held_result = result;
      held_tag = result_tag;
    end
  end

  initial begin
    lfsr = 32'd22;
    rst_n = 1'b0;
    req = 1'b0;
    op = div_pkg::OP_DIV;
    op1 = '0;
    op2 = '0;
    tag = '0;
    stall = 1'b0;
    stall_on = 1'b0;
    timed_out = 1'b0;
    next_tag = '0;
    issued = 0;
    returned = 0;
    errors = 0;
    tests_run = 0;
    for (int i = 0; i < 2**div_pkg::TAG_W; i++) begin
      pending[i] = 1'b0;
    end
    repeat (3) @(posedge clk);
    rst_n <= 1'b1;

    @(negedge clk);
    check_bit(busy, 1'b0, "busy after reset");
    check_bit(done, 1'b0, "done after reset");
    report("reset state");

    issue(div_pkg::OP_DIV, div_pkg::XLEN'(-100), div_pkg::XLEN'(7));
    wait_done();
    check_cycles(cycles, 34, "accept to done");
    drain();
    report("single request latency");

    issue(div_pkg::OP_DIV, most_negative(), '1);
    issue(div_pkg::OP_REM, most_negative(), '1);
    issue(div_pkg::OP_DIVU, pick_operand(), '0);
    issue(div_pkg::OP_REM, pick_operand(), '0);
    repeat (60) issue(random_op(), pick_operand(), pick_operand());
    drain();
    report("random ops and corner cases");

    // Empty unit takes four back-to-back requests
    for (int i = 0; i < div_pkg::NUM_LANES; i++) begin
      @(posedge clk);
      send(random_op(), pick_operand(), pick_operand());
    end
    advance();
    @(negedge clk);
    check_bit(busy, 1'b1, "busy with every lane taken");
    wait_free();
    drain();
    report("all lanes filled");

    stall_on = 1'b1;
    repeat (40) issue(random_op(), pick_operand(), pick_operand());
    drain();
    report("random stall");

    repeat (300) issue(random_op(), pick_operand(), pick_operand());
    drain();
    report("long mixed run");

    for (int i = 0; i < 2**div_pkg::TAG_W; i++) begin
      if (pending[i]) begin
        errors++;
        $display("Tag %0d was accepted but never returned", i);
      end
    end
    errors += DUT.u_props.fail_count;
    $display("Summary: %0d tests, %0d issued, %0d returned, %0d errors",
             tests_run, issued, returned, errors);
    if (errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

//--- list.f
logic/div_pkg.sv
logic/div_dispatch.sv
logic/div_lane.sv
logic/div_collect.sv
logic/div_cluster.sv
tests/div_tb_props.sv
tests/div_tb.sv

//--- run.sh
#!/bin/sh
# Build the divide cluster bench with Verilator, run it, and judge the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
  --top-module div_tb -f list.f --Mdir obj_dir

status=0
./obj_dir/Vdiv_tb > sim.log 2>&1 || status=$?
cat sim.log

if [ "$status" -ne 0 ] || grep -q "Checks failed" sim.log; then
  echo "Simulation FAILED"
  exit 1
fi
echo "Simulation passed"
